// ==== verilog.f ====
+incdir+include
verilog/fe_pkg.sv
verilog/inst_mem.sv
verilog/pipe_reg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/branch_stage.sv
verilog/fe_top.sv
tests/clk_gen.sv
tests/fe_asserts.sv
tests/fe_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module fe_tb -f verilog.f -o fe_sim \
  && ./obj_dir/fe_sim | tee /dev/stderr | grep -q "All tests passed" \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }

// ==== tests/fe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_macros.svh"

module fe_tb import fe_pkg::*; ();

  localparam int IMEM_DEPTH  = 1 << `FE_IMEM_AW;
  localparam int RST_CYCLES  = 4;
  localparam int TAIL_CYCLES = 8;

  logic                   clk;
  logic                   por_n;
  logic                   tb_rst_n;
  logic                   rst_n;
  logic                   ready;
  logic                   imem_we;
  logic [`FE_IMEM_AW-1:0] imem_waddr;
  word_t                  imem_wdata;
  decoded_instr_t         decoded;
  logic                   valid;

  // Program image and the decoded form each word should take
  word_t          prog_word [IMEM_DEPTH];
  decoded_instr_t prog_exp [IMEM_DEPTH];
  int             prog_len;
  decoded_instr_t exp_q [$];

  logic [15:0] lfsr_state;
  int          errors;
  int          test_errs;
  int          tests_run;
  int          tests_failed;
  int          cycle_count = 0;
  int          cycle_limit;

  clk_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (por_n)
  );

  assign rst_n = por_n & tb_rst_n;

  fe_top fe_top_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .ready_i      (ready),
    .imem_we_i    (imem_we),
    .imem_waddr_i (imem_waddr),
    .imem_wdata_i (imem_wdata),
    .decoded_o    (decoded),
    .valid_o      (valid)
  );

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: run went past %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [15:0] galois_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Assembler that records the expected decode next to each word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic decoded_instr_t make_exp(input opcode_e op, input func_unit_e fu,
                                              input logic wv, input int rd, input int rs1,
                                              input int rs2, input int cond, input int imm);
    decoded_instr_t e;
    e           = '0;
    e.opcode    = op;
    e.func_unit = fu;
    e.w_v       = wv;
    e.dest_id   = reg_id_t'(rd);
    e.src1_id   = reg_id_t'(rs1);
    e.src2_id   = reg_id_t'(rs2);
    e.cond      = cond_t'(cond);
    e.imm       = word_t'(imm);
    return e;
  endfunction

  task automatic emit(input word_t w, input decoded_instr_t e);
    e.pc = pc_t'(prog_len);
    prog_word[prog_len[`FE_IMEM_AW-1:0]] = w;
    prog_exp[prog_len[`FE_IMEM_AW-1:0]]  = e;
    prog_len++;
  endtask

  task automatic asm_add(input int rd, input int rs1, input int rs2);
    emit({OP_ADD, 3'(rd), 3'(rs1), 3'(rs2), 3'b000},
         make_exp(OP_ADD, FU_ALU, 1'b1, rd, rs1, rs2, 0, 0));
  endtask

  // ADDI, LOAD and STORE share a format where ra is rs2 for STORE
  task automatic asm_rri(input opcode_e op, input int ra, input int rs1, input int imm);
    decoded_instr_t e;
    if (op == OP_STORE) begin
      e = make_exp(op, FU_MEM, 1'b0, 0, rs1, ra, 0, imm);
    end else if (op == OP_LOAD) begin
      e = make_exp(op, FU_MEM, 1'b1, ra, rs1, 0, 0, imm);
    end else begin
      e = make_exp(op, FU_ALU, 1'b1, ra, rs1, 0, 0, imm);
    end
    emit({op, 3'(ra), 3'(rs1), 6'(imm)}, e);
  endtask

  task automatic asm_movi(input int rd, input int imm);
    emit({OP_MOVI, 3'(rd), 9'(imm)}, make_exp(OP_MOVI, FU_ALU, 1'b1, rd, 0, 0, 0, imm));
  endtask

  task automatic asm_b(input int off);
    emit({OP_B, 12'(off)}, make_exp(OP_B, FU_BRANCH, 1'b0, 0, 0, 0, 0, off));
  endtask

  task automatic asm_bcc(input int cond, input int off);
    emit({OP_BCC, 3'(cond), 9'(off)}, make_exp(OP_BCC, FU_BRANCH, 1'b0, 0, 0, 0, cond, off));
  endtask

  // NOP or an undefined code
  task automatic asm_raw(input word_t w);
    emit(w, make_exp(OP_NOP, FU_NOOP, 1'b0, 0, 0, 0, 0, 0));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Walks the program as the predictor would until a B to itself
  task automatic build_expected();
    logic [`FE_IMEM_AW-1:0] pc;
    decoded_instr_t         e;
    int                     steps;
    exp_q.delete();
    pc    = '0;
    steps = 0;
    while (steps < IMEM_DEPTH) begin
      e = prog_exp[pc];
      steps++;
      if (e.opcode == OP_B) begin
        if (e.imm == '0) begin
          break;
        end
        pc = pc + e.imm[`FE_IMEM_AW-1:0];
      end else if (e.opcode == OP_BCC) begin
        e.spec_taken = e.imm[`FE_WORD_W-1];
        exp_q.push_back(e);
        pc = e.spec_taken ? pc + e.imm[`FE_IMEM_AW-1:0] : pc + `FE_IMEM_AW'(1);
      end else begin
        if (e.func_unit != FU_NOOP) begin
          exp_q.push_back(e);
        end
        pc = pc + `FE_IMEM_AW'(1);
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Drivers and checkers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic note_error();
    errors++;
    test_errs++;
  endtask

  task automatic fill_memory();
    for (int a = 0; a < IMEM_DEPTH; a++) begin
      @(posedge clk);
      #1;
      imem_we    = 1'b1;
      imem_waddr = a[`FE_IMEM_AW-1:0];
      // Undefined opcode tagged with its own address
      imem_wdata = {4'hE, a[11:0]};
    end
    @(posedge clk);
    #1;
    imem_we = 1'b0;
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    #1;
    tb_rst_n = 1'b0;
    repeat (RST_CYCLES) begin
      @(negedge clk);
      if (valid) begin
        $display("valid_o was high while reset was held at %0t", $time);
        note_error();
      end
      @(posedge clk);
    end
    #1;
    tb_rst_n = 1'b1;
  endtask

  task automatic start_test();
    test_errs = 0;
    prog_len  = 0;
    @(posedge clk);
    #1;
    ready = 1'b0;
  endtask

  // Pipe is frozen by ready low while the words go in
  task automatic load_and_reset();
    // Load, reset, a random-ready run and the tail for this program
    cycle_limit += prog_len * 5 + 40;
    for (int i = 0; i < prog_len; i++) begin
      @(posedge clk);
      #1;
      imem_we    = 1'b1;
      imem_waddr = i[`FE_IMEM_AW-1:0];
      imem_wdata = prog_word[i[`FE_IMEM_AW-1:0]];
    end
    @(posedge clk);
    #1;
    imem_we = 1'b0;
    pulse_reset();
    build_expected();
  endtask

  task automatic run_check(input string name, input bit rand_ready, input int stop_after);
    int got;
    got = 0;
    while (got < stop_after) begin
      @(posedge clk);
      #1;
      if (rand_ready) begin
        ready      = lfsr_state[0];
        lfsr_state = galois_step(lfsr_state);
      end else begin
        ready = 1'b1;
      end
      @(negedge clk);
      if (valid && ready) begin
        if (decoded !== exp_q[got]) begin
          $display("MISMATCH at %0t: %s item %0d (pc %h) got %h expected %h",
                   $time, name, got, exp_q[got].pc, decoded, exp_q[got]);
          note_error();
        end
        got++;
      end
    end
  endtask

  task automatic check_tail(input string name);
    repeat (TAIL_CYCLES) begin
      @(posedge clk);
      #1;
      ready = 1'b1;
      @(negedge clk);
      if (valid) begin
        $display("%s: extra instruction at pc %h delivered at %0t", name, decoded.pc, $time);
        note_error();
      end
    end
  endtask

  task automatic run_test(input string name, input bit rand_ready);
    run_check(name, rand_ready, exp_q.size());
    check_tail(name);
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("%s: %s, %0d errors", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Programs and tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic straight_prog();
    asm_add(1, 2, 3);
    asm_rri(OP_ADDI, 4, 5, -3);
    asm_rri(OP_ADDI, 6, 7, 31);
    asm_rri(OP_LOAD, 2, 1, -32);
    asm_rri(OP_STORE, 3, 4, 17);
    asm_movi(5, 511);
    asm_movi(0, 'h1a5);
    asm_b(0);
  endtask

  // Backward BCC at 6 lands on 2 and forward BCC at 8 falls through
  task automatic branch_prog();
    asm_movi(1, 3);
    asm_b(4);
    asm_add(2, 1, 1);
    asm_b(5);
    asm_rri(OP_ADDI, 3, 3, 1);
    asm_rri(OP_ADDI, 4, 1, -1);
    asm_bcc(1, -4);
    asm_movi(6, 7);
    asm_bcc(3, 2);
    asm_rri(OP_LOAD, 5, 2, 0);
    asm_b(0);
  endtask

  task automatic test_straight_line();
    start_test();
    straight_prog();
    load_and_reset();
    run_test("straight_line", 1'b0);
  endtask

  task automatic test_nop_undefined();
    start_test();
    asm_add(7, 6, 5);
    asm_raw(16'h0000);
    asm_rri(OP_ADDI, 1, 1, 1);
    asm_raw(16'h6123);
    asm_raw(16'hF00F);
    asm_movi(3, 2);
    asm_raw(16'h7FFF);
    asm_rri(OP_LOAD, 4, 3, 5);
    asm_b(0);
    load_and_reset();
    run_test("nop_undefined", 1'b0);
  endtask

  task automatic test_uncond_branch();
    start_test();
    asm_movi(1, 1);
    asm_b(4);
    asm_add(2, 2, 2);
    asm_add(3, 3, 3);
    asm_rri(OP_ADDI, 4, 4, 4);
    asm_rri(OP_ADDI, 5, 5, 5);
    asm_b(3);
    asm_movi(6, 6);
    asm_movi(7, 7);
    asm_add(1, 2, 3);
    asm_b(0);
    load_and_reset();
    run_test("uncond_branch", 1'b0);
  endtask

  task automatic test_cond_branch();
    start_test();
    branch_prog();
    load_and_reset();
    run_test("cond_branch", 1'b0);
  endtask

  task automatic test_random_ready();
    start_test();
    branch_prog();
    load_and_reset();
    run_test("random_ready", 1'b1);
  endtask

  task automatic test_mid_run_reset();
    start_test();
    straight_prog();
    load_and_reset();
    run_check("mid_run_reset", 1'b0, 3);
    pulse_reset();
    run_test("mid_run_reset", 1'b0);
  endtask

  initial begin
    ready        = 1'b0;
    imem_we      = 1'b0;
    imem_waddr   = '0;
    imem_wdata   = '0;
    tb_rst_n     = 1'b1;
    lfsr_state   = 16'd34069;
    errors       = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    prog_len     = 0;
    // Power-on reset and memory fill before the tests add their own share
    cycle_limit  = 200 + IMEM_DEPTH + 16;
    wait (por_n);
    fill_memory();
    test_straight_line();
    test_nop_undefined();
    test_uncond_branch();
    test_cond_branch();
    test_random_ready();
    test_mid_run_reset();
    $display("Tests run %0d, failing %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/fe_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_asserts import fe_pkg::*; (
  input logic           clk_i,
  input logic           rst_n_i,
  input logic           ready_i,
  input logic           redirect_i,
  input logic           valid_i,
  input decoded_instr_t decoded_i
);

  // Nothing leaves the front end while reset is held
  no_valid_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !valid_i)
    else $error("valid_o high during reset");

  // A stalled edge must leave the outputs untouched
  stable_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(!ready_i && rst_n_i) |-> $stable({valid_i, decoded_i}))
    else $error("outputs changed across a stalled edge");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Redirect bubbles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  bubble_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (redirect_i && ready_i) |=> !valid_i)
    else $error("valid_o one cycle after redirect");

  bubble_second: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(redirect_i && ready_i, 2) |-> !valid_i)
    else $error("valid_o two cycles after redirect");

  // A delivered word must have decoded to a real opcode
  valid_real_op: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> (decoded_i.opcode != OP_NOP))
    else $error("valid_o with a NOP opcode");

endmodule

bind fe_top fe_asserts fe_asserts_i (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .ready_i    (ready_i),
  .redirect_i (redirect),
  .valid_i    (valid_o),
  .decoded_i  (decoded_o)
);

`default_nettype wire

// ==== tests/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int HALF_PERIOD = 4,
  parameter int RST_CYCLES  = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns clock
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Power-on reset, released just after an edge like the other stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/fe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_macros.svh"

module fe_top import fe_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   ready_i,
  input  logic                   imem_we_i,
  input  logic [`FE_IMEM_AW-1:0] imem_waddr_i,
  input  word_t                  imem_wdata_i,
  output decoded_instr_t         decoded_o,
  output logic                   valid_o
);

  logic           stall;
  logic           redirect;
  logic           flush;
  pc_t            target;
  fetch_pkt_t     fd_pkt;
  logic           fd_v;
  decoded_instr_t db_dec;
  logic           db_v;

  // Whole pipe freezes while the back end is not ready
  assign stall = ~ready_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fetch_stage fetch_stage_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall),
    .redirect_i   (redirect),
    .target_i     (target),
    .flush_i      (flush),
    .imem_we_i    (imem_we_i),
    .imem_waddr_i (imem_waddr_i),
    .imem_wdata_i (imem_wdata_i),
    .pkt_o        (fd_pkt),
    .v_o          (fd_v)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  decode_stage decode_stage_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stall_i (stall),
    .flush_i (flush),
    .pkt_i   (fd_pkt),
    .v_i     (fd_v),
    .dec_o   (db_dec),
    .v_o     (db_v)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Branch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  branch_stage branch_stage_i (
    .dec_i      (db_dec),
    .v_i        (db_v),
    .redirect_o (redirect),
    .target_o   (target),
    .flush_o    (flush),
    .decoded_o  (decoded_o),
    .valid_o    (valid_o)
  );

endmodule

`default_nettype wire

// ==== verilog/branch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_macros.svh"

module branch_stage import fe_pkg::*; (
  input  decoded_instr_t dec_i,
  input  logic           v_i,
  output logic           redirect_o,
  output pc_t            target_o,
  output logic           flush_o,
  output decoded_instr_t decoded_o,
  output logic           valid_o
);

  logic is_b;
  logic is_bcc;
  logic bcc_taken;
  logic taken;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Target and static prediction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // PC relative, offset already sign extended by decode
  assign target_o = dec_i.pc + dec_i.imm;

  assign is_b   = v_i && (dec_i.opcode == OP_B);
  assign is_bcc = v_i && (dec_i.opcode == OP_BCC);

  // Backward taken, forward not taken
  assign bcc_taken = is_bcc && dec_i.imm[`FE_WORD_W-1];
  assign taken     = is_b || bcc_taken;

  // Two younger words are on the wrong path
  assign redirect_o = taken;
  assign flush_o    = taken;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output to back end
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    decoded_o            = dec_i;
    decoded_o.spec_taken = bcc_taken;
  end

  // Unconditional branches are fully handled here and never leave
  assign valid_o = v_i && (dec_i.func_unit != FU_NOOP) && (dec_i.opcode != OP_B);

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_macros.svh"

module decode_stage import fe_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           stall_i,
  input  logic           flush_i,
  input  fetch_pkt_t     pkt_i,
  input  logic           v_i,
  output decoded_instr_t dec_o,
  output logic           v_o
);

  word_t          instr;
  logic [3:0]     op_field;
  reg_id_t        rd_field;
  reg_id_t        rs1_field;
  reg_id_t        rs2_field;
  word_t          imm_s6;
  word_t          imm_z9;
  word_t          imm_s9;
  word_t          imm_s12;
  decoded_instr_t dec_d;

  assign instr = pkt_i.instr;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field extraction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign op_field  = instr[15:12];
  assign rd_field  = instr[11:9];
  assign rs1_field = instr[8:6];
  assign rs2_field = instr[5:3];

  // Immediate formats
  assign imm_s6  = {{(`FE_WORD_W-6){instr[5]}}, instr[5:0]};
  assign imm_z9  = {{(`FE_WORD_W-9){1'b0}}, instr[8:0]};
  assign imm_s9  = {{(`FE_WORD_W-9){instr[8]}}, instr[8:0]};
  assign imm_s12 = {{(`FE_WORD_W-12){instr[11]}}, instr[11:0]};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    // Unused fields stay zero
    dec_d           = '0;
    dec_d.pc        = pkt_i.pc;
    dec_d.opcode    = OP_NOP;
    dec_d.func_unit = FU_NOOP;

    case (op_field)
      OP_ADD: begin
        dec_d.opcode    = OP_ADD;
        dec_d.func_unit = FU_ALU;
        dec_d.w_v       = 1'b1;
        dec_d.dest_id   = rd_field;
        dec_d.src1_id   = rs1_field;
        dec_d.src2_id   = rs2_field;
      end
      OP_ADDI: begin
        dec_d.opcode    = OP_ADDI;
        dec_d.func_unit = FU_ALU;
        dec_d.w_v       = 1'b1;
        dec_d.dest_id   = rd_field;
        dec_d.src1_id   = rs1_field;
        dec_d.imm       = imm_s6;
      end
      OP_LOAD: begin
        dec_d.opcode    = OP_LOAD;
        dec_d.func_unit = FU_MEM;
        dec_d.w_v       = 1'b1;
        dec_d.dest_id   = rd_field;
        dec_d.src1_id   = rs1_field;
        dec_d.imm       = imm_s6;
      end
      OP_STORE: begin
        // Store data register sits where rd would be
        dec_d.opcode    = OP_STORE;
        dec_d.func_unit = FU_MEM;
        dec_d.src1_id   = rs1_field;
        dec_d.src2_id   = rd_field;
        dec_d.imm       = imm_s6;
      end
      OP_MOVI: begin
        dec_d.opcode    = OP_MOVI;
        dec_d.func_unit = FU_ALU;
        dec_d.w_v       = 1'b1;
        dec_d.dest_id   = rd_field;
        dec_d.imm       = imm_z9;
      end
      OP_B: begin
        dec_d.opcode    = OP_B;
        dec_d.func_unit = FU_BRANCH;
        dec_d.imm       = imm_s12;
      end
      OP_BCC: begin
        dec_d.opcode    = OP_BCC;
        dec_d.func_unit = FU_BRANCH;
        dec_d.cond      = cond_t'(instr[11:9]);
        dec_d.imm       = imm_s9;
      end
      default: begin
        // Undefined codes fall through as a NOP
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode / branch register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  pipe_reg #(
    .WIDTH ($bits(decoded_instr_t))
  ) db_reg_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .flush_i (flush_i),
    .v_i     (v_i),
    .data_i  (dec_d),
    .v_o     (v_o),
    .data_o  (dec_o)
  );

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_macros.svh"

module fetch_stage import fe_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   stall_i,
  input  logic                   redirect_i,
  input  pc_t                    target_i,
  input  logic                   flush_i,
  input  logic                   imem_we_i,
  input  logic [`FE_IMEM_AW-1:0] imem_waddr_i,
  input  word_t                  imem_wdata_i,
  output fetch_pkt_t             pkt_o,
  output logic                   v_o
);

  pc_t        pc_q;
  pc_t        pc_d;
  word_t      instr;
  fetch_pkt_t pkt_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Program counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Branch target beats sequential fetch
  assign pc_d = redirect_i ? target_i : pc_q + pc_t'(1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= '0;
    end else if (!stall_i) begin
      pc_q <= pc_d;
    end
  end

  inst_mem inst_mem_i (
    .clk_i   (clk_i),
    .we_i    (imem_we_i),
    .waddr_i (imem_waddr_i),
    .wdata_i (imem_wdata_i),
    .raddr_i (pc_q[`FE_IMEM_AW-1:0]),
    .rdata_o (instr)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fetch / decode register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign pkt_d.pc    = pc_q;
  assign pkt_d.instr = instr;

  // Every fetched word is valid, only a flush or reset drops it
  pipe_reg #(
    .WIDTH ($bits(fetch_pkt_t))
  ) fd_reg_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .flush_i (flush_i),
    .v_i     (1'b1),
    .data_i  (pkt_d),
    .v_o     (v_o),
    .data_o  (pkt_o)
  );

endmodule

`default_nettype wire

// ==== verilog/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter int WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             stall_i,
  input  logic             flush_i,
  input  logic             v_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             v_o,
  output logic [WIDTH-1:0] data_o
);

  logic             v_q;
  logic [WIDTH-1:0] data_q;

  // Stall wins over flush, flush wins over load
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      v_q <= 1'b0;
    end else if (!stall_i) begin
      v_q <= flush_i ? 1'b0 : v_i;
    end
  end

  // Payload is don't-care whenever valid is low
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      data_q <= data_i;
    end
  end

  assign v_o    = v_q;
  assign data_o = data_q;

endmodule

`default_nettype wire

// ==== verilog/inst_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_macros.svh"

module inst_mem import fe_pkg::*; (
  input  logic                   clk_i,
  input  logic                   we_i,
  input  logic [`FE_IMEM_AW-1:0] waddr_i,
  input  word_t                  wdata_i,
  input  logic [`FE_IMEM_AW-1:0] raddr_i,
  output word_t                  rdata_o
);

  localparam int DEPTH = 1 << `FE_IMEM_AW;

  word_t mem [DEPTH];

  // Program load port
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Read is combinational so fetch sees the word in the same cycle
  assign rdata_o = mem[raddr_i];

endmodule

`default_nettype wire

// ==== verilog/fe_pkg.sv ====
`default_nettype none

`include "fe_macros.svh"

package fe_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Width types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [`FE_WORD_W-1:0] word_t;
  // Word address, one instruction per step
  typedef logic [`FE_WORD_W-1:0] pc_t;
  typedef logic [`FE_REG_W-1:0]  reg_id_t;
  // Condition code, left for the back end to interpret
  typedef logic [2:0]            cond_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_ADD   = 4'd1,
    OP_ADDI  = 4'd2,
    OP_LOAD  = 4'd3,
    OP_STORE = 4'd4,
    OP_MOVI  = 4'd5,
    OP_B     = 4'd8,
    OP_BCC   = 4'd9
  } opcode_e;

  typedef enum logic [1:0] {
    FU_NOOP   = 2'd0,
    FU_ALU    = 2'd1,
    FU_MEM    = 2'd2,
    FU_BRANCH = 2'd3
  } func_unit_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    pc_t   pc;
    word_t instr;
  } fetch_pkt_t;

  typedef struct packed {
    pc_t        pc;
    opcode_e    opcode;
    func_unit_e func_unit;
    logic       w_v;
    reg_id_t    dest_id;
    reg_id_t    src1_id;
    reg_id_t    src2_id;
    cond_t      cond;
    word_t      imm;
    logic       spec_taken;
  } decoded_instr_t;

endpackage

`default_nettype wire

// ==== include/fe_macros.svh ====
`ifndef FE_MACROS_SVH
`define FE_MACROS_SVH

// Instruction word and program counter width
`define FE_WORD_W 16

// Instruction memory address width, 256 words
`define FE_IMEM_AW 8

// Architectural register file size
`define FE_NUM_REGS 8

// Register id width follows the register count
`define FE_REG_W $clog2(`FE_NUM_REGS)

`endif
